// File: hdl/vs_mux_pkg.sv
//////////////////////////////////////////////////
// Output mux shared definitions
// Stream widths, buffered word layout and the
// arbiter state encoding
//////////////////////////////////////////////////

package vs_mux_pkg;

  // Stream widths
  localparam int DATA_WIDTH  = 64;
  localparam int KEEP_WIDTH  = DATA_WIDTH / 8;
  localparam int TUSER_WIDTH = 16;

  // One stream beat as stored in a port FIFO
  // and as presented on the merged output
  typedef struct packed {
    logic                   tlast;
    logic [TUSER_WIDTH-1:0] tuser;
    logic [KEEP_WIDTH-1:0]  tkeep;
    logic [DATA_WIDTH-1:0]  tdata;
  } axis_word_t;

  // Arbiter states
  // ARB_IDLE searches for a queue with data,
  // ARB_PKT stays on one queue until tlast
  typedef enum logic [0:0] {
    ARB_IDLE = 1'b0,
    ARB_PKT  = 1'b1
  } arb_state_t;

endpackage

// File: hdl/axis_word_if.sv
//////////////////////////////////////////////////
// Buffered stream word link between one port
// FIFO head and the packet arbiter
//////////////////////////////////////////////////

interface axis_word_if;

  import vs_mux_pkg::*;

  axis_word_t word;
  // Head present whenever the FIFO is not empty
  logic       valid;
  // Pop request for the next rising edge
  logic       ready;

  modport fifo (
    output word,
    output valid,
    input  ready
  );

  modport arbiter (
    input  word,
    input  valid,
    output ready
  );

endinterface

// File: hdl/pkt_fifo.sv
//////////////////////////////////////////////////
// Per-port fall-through word FIFO
// Head is always visible, input is throttled at
// one word below full
//////////////////////////////////////////////////

module pkt_fifo #(
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                   axis_aclk,
  input  logic                   axis_resetn,
  input  vs_mux_pkg::axis_word_t in_word,
  input  logic                   in_valid,
  output logic                   in_ready,
  axis_word_if.fifo              q
);

  import vs_mux_pkg::*;

  localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

  axis_word_t                 mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0]   count;
  logic                       empty;
  logic                       nearly_full;
  logic                       wr_en;
  logic                       rd_en;

  assign empty       = (count == '0);
  // Keeps one slot of slack for the upstream port
  assign nearly_full = (count >= (FIFO_DEPTH_BITS + 1)'(DEPTH - 1));

  assign in_ready = ~nearly_full;
  assign wr_en    = in_valid & in_ready;
  assign rd_en    = q.ready & ~empty;

  // Fall-through head
  assign q.word  = mem[rd_ptr];
  assign q.valid = ~empty;

  // Storage array
  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_word;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// File: hdl/rr_pkt_arbiter.sv
//////////////////////////////////////////////////
// Round-robin packet arbiter
// Merges FIFO heads onto one stream, one whole
// packet at a time
//////////////////////////////////////////////////

module rr_pkt_arbiter #(
  parameter int NUM_QUEUES = 4
) (
  input  logic                   axis_aclk,
  input  logic                   axis_resetn,
  axis_word_if.arbiter           q [NUM_QUEUES],
  output vs_mux_pkg::axis_word_t out_word,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import vs_mux_pkg::*;

  localparam int PTR_WIDTH = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

  axis_word_t            head_word [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] head_valid;
  logic [NUM_QUEUES-1:0] rd_en;

  arb_state_t            state;
  arb_state_t            state_next;
  logic [PTR_WIDTH-1:0]  cur_queue;
  logic [PTR_WIDTH-1:0]  cur_queue_next;
  logic [PTR_WIDTH-1:0]  cur_queue_plus1;
  logic                  xfer;

  // Queue heads and pops as plain arrays
  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_q
    assign head_word[i]  = q[i].word;
    assign head_valid[i] = q[i].valid;
    assign q[i].ready    = rd_en[i];
  end

  assign cur_queue_plus1 = (cur_queue == PTR_WIDTH'(NUM_QUEUES - 1)) ?
                           '0 : cur_queue + 1'b1;

  // Selected head straight to the output
  assign out_word  = head_word[cur_queue];
  assign out_valid = head_valid[cur_queue];
  assign xfer      = out_valid & out_ready;

  // Pop the selected queue on each transfer
  always_comb begin
    rd_en = '0;
    if (xfer) begin
      rd_en[cur_queue] = 1'b1;
    end
  end

  always_comb begin
    state_next     = state;
    cur_queue_next = cur_queue;
    case (state)
      ARB_IDLE: begin
        if (!out_valid) begin
          // Empty queue moves on to the next port
          cur_queue_next = cur_queue_plus1;
        end else if (xfer) begin
          // Single-word packet completes right away
          if (out_word.tlast) begin
            cur_queue_next = cur_queue_plus1;
          end else begin
            state_next = ARB_PKT;
          end
        end
      end
      ARB_PKT: begin
        // Hold the port until the end of packet
        if (xfer && out_word.tlast) begin
          state_next     = ARB_IDLE;
          cur_queue_next = cur_queue_plus1;
        end
      end
      default: begin
        state_next = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state     <= ARB_IDLE;
      cur_queue <= '0;
    end else begin
      state     <= state_next;
      cur_queue <= cur_queue_next;
    end
  end

endmodule

// File: hdl/vs_output_mux.sv
//////////////////////////////////////////////////
// Virtual-switch output mux
// Buffers each input stream and merges them by
// round-robin packet arbitration
//////////////////////////////////////////////////

module vs_output_mux #(
  parameter int NUM_QUEUES      = 4,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                               axis_aclk,
  input  logic                               axis_resetn,
  // Input streams, one per virtual switch
  input  logic [vs_mux_pkg::DATA_WIDTH-1:0]  s_tdata [NUM_QUEUES],
  input  logic [vs_mux_pkg::KEEP_WIDTH-1:0]  s_tkeep [NUM_QUEUES],
  input  logic [vs_mux_pkg::TUSER_WIDTH-1:0] s_tuser [NUM_QUEUES],
  input  logic                               s_tvalid [NUM_QUEUES],
  input  logic                               s_tlast [NUM_QUEUES],
  output logic                               s_tready [NUM_QUEUES],
  // Merged output stream
  output logic [vs_mux_pkg::DATA_WIDTH-1:0]  m_tdata,
  output logic [vs_mux_pkg::KEEP_WIDTH-1:0]  m_tkeep,
  output logic [vs_mux_pkg::TUSER_WIDTH-1:0] m_tuser,
  output logic                               m_tvalid,
  output logic                               m_tlast,
  input  logic                               m_tready
);

  import vs_mux_pkg::*;

  axis_word_t in_word [NUM_QUEUES];
  axis_word_t out_word;

  axis_word_if q_if [NUM_QUEUES] ();

  // One FIFO per input port
  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_port
    assign in_word[i] = '{
      tlast: s_tlast[i],
      tuser: s_tuser[i],
      tkeep: s_tkeep[i],
      tdata: s_tdata[i]
    };

    pkt_fifo #(
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
    ) i_pkt_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .in_word     (in_word[i]),
      .in_valid    (s_tvalid[i]),
      .in_ready    (s_tready[i]),
      .q           (q_if[i])
    );
  end

  rr_pkt_arbiter #(
    .NUM_QUEUES (NUM_QUEUES)
  ) i_rr_pkt_arbiter (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .q           (q_if),
    .out_word    (out_word),
    .out_valid   (m_tvalid),
    .out_ready   (m_tready)
  );

  // Unpack the merged word
  assign m_tdata = out_word.tdata;
  assign m_tkeep = out_word.tkeep;
  assign m_tuser = out_word.tuser;
  assign m_tlast = out_word.tlast;

endmodule

// File: verification/tb_vs_output_mux.sv
//////////////////////////////////////////////////
// Testbench for the virtual-switch output mux
// Random packets per port, per-port reference
// queues, fill, round-robin and stall checks
//////////////////////////////////////////////////

module tb_vs_output_mux;

  import vs_mux_pkg::*;

  localparam int NUM_QUEUES      = 4;
  localparam int FIFO_DEPTH_BITS = 4;
  localparam int FILL_WORDS      = (1 << FIFO_DEPTH_BITS) - 1;
  localparam int MIN_WORDS       = 50;

  // Input and output drive modes
  localparam int SEND_NONE    = 0;
  localparam int SEND_ALL     = 1;
  localparam int SEND_RANDOM  = 2;
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic                   axis_aclk = 1'b0;
  logic                   axis_resetn;
  logic [DATA_WIDTH-1:0]  s_tdata [NUM_QUEUES];
  logic [KEEP_WIDTH-1:0]  s_tkeep [NUM_QUEUES];
  logic [TUSER_WIDTH-1:0] s_tuser [NUM_QUEUES];
  logic                   s_tvalid [NUM_QUEUES];
  logic                   s_tlast [NUM_QUEUES];
  logic                   s_tready [NUM_QUEUES];
  logic [DATA_WIDTH-1:0]  m_tdata;
  logic [KEEP_WIDTH-1:0]  m_tkeep;
  logic [TUSER_WIDTH-1:0] m_tuser;
  logic                   m_tvalid;
  logic                   m_tlast;
  logic                   m_tready;

  integer                 seed = 32'h0127073e;
  axis_word_t             tx_q [NUM_QUEUES][$];
  axis_word_t             exp_q [NUM_QUEUES][$];
  logic                   accepted [NUM_QUEUES];
  int                     accept_cnt [NUM_QUEUES];
  logic [NUM_QUEUES-1:0]  fill_done;
  logic                   fill_active = 1'b0;
  logic                   rr_check = 1'b0;
  int                     send_mode = SEND_NONE;
  int                     ready_mode = READY_LOW;
  logic                   in_pkt = 1'b0;
  int                     cur_port = 0;
  int                     last_port = -1;
  int                     pkt_count = 0;
  logic                   stalled = 1'b0;
  axis_word_t             held_word;
  int                     total_words = 0;
  int                     words_checked = 0;
  int                     value_errors = 0;
  int                     other_errors = 0;
  int                     cycle_count = 0;
  int                     cycle_limit = 1000;

  vs_output_mux i_dut (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .s_tdata     (s_tdata),
    .s_tkeep     (s_tkeep),
    .s_tuser     (s_tuser),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tready    (s_tready),
    .m_tdata     (m_tdata),
    .m_tkeep     (m_tkeep),
    .m_tuser     (m_tuser),
    .m_tvalid    (m_tvalid),
    .m_tlast     (m_tlast),
    .m_tready    (m_tready)
  );

  always #50 axis_aclk = ~axis_aclk;

  task automatic check_word(input string name, input axis_word_t got, input axis_word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic print_summary();
    $display("Checked %0d of %0d words: %0d value errors, %0d other errors",
             words_checked, total_words, value_errors, other_errors);
  endtask

  task automatic build_packets();
    axis_word_t w;
    int         len;
    int         seq;
    for (int p = 0; p < NUM_QUEUES; p++) begin
      seq = 0;
      while (tx_q[p].size() < MIN_WORDS) begin
        len = 1 + int'($unsigned($random(seed)) % 6);
        for (int i = 0; i < len; i++) begin
          // Port, packet number and word index
          w.tdata = {16'(p), 32'(seq), 16'(i)};
          w.tkeep = KEEP_WIDTH'($random(seed));
          w.tuser = TUSER_WIDTH'($random(seed));
          w.tlast = (i == len - 1);
          tx_q[p].push_back(w);
        end
        seq++;
      end
      total_words += tx_q[p].size();
    end
  endtask

  function automatic logic all_drained();
    logic done;
    done = !in_pkt;
    for (int p = 0; p < NUM_QUEUES; p++) begin
      if (tx_q[p].size() != 0 || exp_q[p].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // Runs at the falling edge when all DUT signals have settled
  task automatic sample_outputs();
    axis_word_t got;
    axis_word_t exp;
    int         port;
    got = {m_tlast, m_tuser, m_tkeep, m_tdata};
    if (stalled) begin
      check_level("m_tvalid", m_tvalid, 1'b1);
      check_word("m_word", got, held_word);
    end
    stalled   = m_tvalid && !m_tready;
    held_word = got;
    if (m_tvalid && m_tready) begin
      if (!in_pkt) begin
        port = int'(m_tdata[DATA_WIDTH-1 -: 16]);
        if (port >= NUM_QUEUES) begin
          other_errors++;
          $display("Output packet carries unknown port number %0d", port);
        end else if (exp_q[port].size() == 0) begin
          other_errors++;
          $display("Output packet from port %0d, which has nothing outstanding", port);
        end else begin
          if (rr_check && last_port >= 0 && port != (last_port + 1) % NUM_QUEUES) begin
            other_errors++;
            $display("Round-robin order broken: port %0d follows port %0d", port, last_port);
          end
          cur_port = port;
          in_pkt   = 1'b1;
        end
      end else if (exp_q[cur_port].size() == 0) begin
        other_errors++;
        $display("Packet from port %0d runs past the words sent", cur_port);
        in_pkt = 1'b0;
      end
      if (in_pkt) begin
        exp = exp_q[cur_port].pop_front();
        check_word("m_word", got, exp);
        words_checked++;
        if (got.tlast) begin
          in_pkt    = 1'b0;
          last_port = cur_port;
          pkt_count++;
        end
      end
    end
    // Input side handshakes
    for (int p = 0; p < NUM_QUEUES; p++) begin
      if (fill_active && !fill_done[p] && !s_tready[p]) begin
        fill_done[p] = 1'b1;
        if (accept_cnt[p] != FILL_WORDS) begin
          other_errors++;
          $display("Port %0d took %0d words before s_tready fell, expected %0d",
                   p, accept_cnt[p], FILL_WORDS);
        end
      end
      accepted[p] = s_tvalid[p] && s_tready[p];
      if (accepted[p]) begin
        exp_q[p].push_back(tx_q[p].pop_front());
        accept_cnt[p]++;
      end
    end
  endtask

  // Runs at the rising edge
  task automatic drive_inputs();
    axis_word_t w;
    int         roll;
    for (int p = 0; p < NUM_QUEUES; p++) begin
      roll = $random(seed);
      // A pending word is held until taken
      if (!s_tvalid[p] || accepted[p]) begin
        if (tx_q[p].size() > 0 &&
            (send_mode == SEND_ALL || (send_mode == SEND_RANDOM && (roll & 3) != 0))) begin
          w = tx_q[p][0];
          s_tvalid[p] <= 1'b1;
          s_tdata[p]  <= w.tdata;
          s_tkeep[p]  <= w.tkeep;
          s_tuser[p]  <= w.tuser;
          s_tlast[p]  <= w.tlast;
        end else begin
          s_tvalid[p] <= 1'b0;
        end
      end
    end
    roll = $random(seed);
    case (ready_mode)
      READY_LOW:  m_tready <= 1'b0;
      READY_HIGH: m_tready <= 1'b1;
      default:    m_tready <= roll[0];
    endcase
  endtask

  task automatic run_cycle();
    @(negedge axis_aclk);
    sample_outputs();
    @(posedge axis_aclk);
    drive_inputs();
  endtask

  always @(posedge axis_aclk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the streams did not drain", cycle_count);
      print_summary();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    axis_resetn = 1'b0;
    m_tready    = 1'b0;
    fill_done   = '0;
    for (int p = 0; p < NUM_QUEUES; p++) begin
      s_tdata[p]    = '0;
      s_tkeep[p]    = '0;
      s_tuser[p]    = '0;
      s_tvalid[p]   = 1'b0;
      s_tlast[p]    = 1'b0;
      accepted[p]   = 1'b0;
      accept_cnt[p] = 0;
    end
    build_packets();
    cycle_limit = 4 * total_words + 200;
    repeat (2) @(posedge axis_aclk);
    axis_resetn <= 1'b1;

    // Idle after reset
    @(negedge axis_aclk);
    check_level("m_tvalid", m_tvalid, 1'b0);
    for (int p = 0; p < NUM_QUEUES; p++) begin
      check_level($sformatf("s_tready[%0d]", p), s_tready[p], 1'b1);
    end

    // Fill all FIFOs with the output stalled
    send_mode   = SEND_ALL;
    ready_mode  = READY_LOW;
    fill_active = 1'b1;
    @(posedge axis_aclk);
    drive_inputs();
    while (fill_done != '1) begin
      run_cycle();
    end
    fill_active = 1'b0;

    // Release the output for two full rounds in port order
    ready_mode = READY_HIGH;
    rr_check   = 1'b1;
    while (pkt_count < 2 * NUM_QUEUES) begin
      run_cycle();
    end
    rr_check = 1'b0;

    // Random traffic and back-pressure until all words are out
    send_mode  = SEND_RANDOM;
    ready_mode = READY_RANDOM;
    while (!all_drained()) begin
      run_cycle();
    end
    send_mode  = SEND_NONE;
    ready_mode = READY_HIGH;
    repeat (20) run_cycle();
    @(negedge axis_aclk);
    check_level("m_tvalid", m_tvalid, 1'b0);

    print_summary();
    if (value_errors == 0 && other_errors == 0 && words_checked == total_words) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
hdl/vs_mux_pkg.sv
hdl/axis_word_if.sv
hdl/pkt_fifo.sv
hdl/rr_pkt_arbiter.sv
hdl/vs_output_mux.sv
verification/tb_vs_output_mux.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the output mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_vs_output_mux
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f flist.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
